//--- Makefile
TOP := tb_udp_axi_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- rtl/axi_burst_master.sv
`timescale 1ns/10ps
module axi_burst_master import udp_axi_pkg::*; (
    input  logic        gmii_rx_clk,
    input  logic        rst,
    input  cmd_t        cmd,
    input  logic        cmd_req,
    output logic        cmd_ack,
    output axi_aw_t     aw,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  axi_b_t      b,
    input  logic        bvalid,
    output logic        bready,
    output axi_aw_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  axi_r_t      r,
    input  logic        rvalid,
    output logic        rready,
    output reply_t      reply,
    output logic        rsp_req,
    input  logic        rsp_ack
);
    master_state_e state;
    cmd_t          cmd_q;
    logic [2:0]    beat;
    logic          accept;
    axi_aw_t       addr_beat;
    logic [3:0]    w_beats;     // W handshakes so far in this burst

    assign accept = (state == st_idle) && cmd_req && !cmd_ack;

    always_comb begin
        addr_beat.id    = cmd_q.id;
        addr_beat.addr  = cmd_q.addr;
        addr_beat.len   = {5'b0, cmd_q.len};
        addr_beat.burst = cmd_q.burst;
    end

    assign aw      = addr_beat;
    assign ar      = addr_beat;
    assign awvalid = (state == st_aw);
    assign wvalid  = (state == st_w);
    assign bready  = (state == st_b);
    assign arvalid = (state == st_ar);
    assign rready  = (state == st_r);

    assign wdata = cmd_q.wdata[beat];
    assign wstrb = 4'hF;                 // full words only
    assign wlast = (beat == cmd_q.len);

    always_ff @(posedge gmii_rx_clk) begin
        if (rst) begin
            state   <= st_idle;
            cmd_ack <= 1'b0;
            rsp_req <= 1'b0;
            beat    <= 3'd0;
        end else begin
            if (cmd_ack && !cmd_req) cmd_ack <= 1'b0;
            unique case (state)
                st_idle: begin
                    if (accept) begin
                        cmd_ack <= 1'b1;
                        beat    <= 3'd0;
                        state   <= (cmd.op == op_read) ? st_ar : st_aw;
                    end
                end
                st_aw: begin
                    if (awready) state <= st_w;
                end
                st_w: begin
                    if (wready) begin
                        if (wlast) begin
                            state <= st_b;
                        end else begin
                            beat <= beat + 3'd1;
                        end
                    end
                end
                st_b: begin
                    if (bvalid) begin
                        rsp_req <= 1'b1;
                        state   <= st_reply;
                    end
                end
                st_ar: begin
                    if (arready) state <= st_r;
                end
                st_r: begin
                    if (rvalid) begin
                        beat <= beat + 3'd1;
                        if (r.last) begin
                            rsp_req <= 1'b1;
                            state   <= st_reply;
                        end
                    end
                end
                st_reply: begin
                    if (rsp_req && rsp_ack) rsp_req <= 1'b0;
                    if (!rsp_req && !rsp_ack) state <= st_idle;  // four-phase done
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (accept) begin
            cmd_q     <= cmd;
            reply.op  <= cmd.op;
            reply.id  <= cmd.id;
            reply.len <= cmd.len;
        end
        if (state == st_b && bvalid) reply.resp <= b.resp;
        if (state == st_r && rvalid) begin
            reply.rdata[beat] <= r.data;
            if (r.last) reply.resp <= r.resp;   // status of final beat
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (rst || (awvalid && awready)) begin
            w_beats <= 4'd0;
        end else if (wvalid && wready) begin
            w_beats <= w_beats + 4'd1;
        end
    end

    assert property (@(posedge gmii_rx_clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw));

    // last flag exactly on the handshake that completes len+1 beats
    assert property (@(posedge gmii_rx_clk) disable iff (rst)
        wvalid && wready |-> wlast == (w_beats == {1'b0, cmd_q.len}));

endmodule

//--- rtl/udp_axi_bridge.sv
`timescale 1ns/10ps
module udp_axi_bridge import udp_axi_pkg::*; (
    input  logic        gmii_rx_clk,
    input  logic        rst,
    input  logic        rec_en,
    input  logic [31:0] rec_data,
    input  logic        rec_pkt_done,
    output logic        tx_start_en,
    output logic [15:0] tx_byte_num,
    input  logic        tx_req,
    output logic [31:0] tx_data,
    input  logic        tx_done,
    output axi_aw_t     aw,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  axi_b_t      b,
    input  logic        bvalid,
    output logic        bready,
    output axi_aw_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  axi_r_t      r,
    input  logic        rvalid,
    output logic        rready
);
    cmd_t   cmd;
    logic   cmd_req;
    logic   cmd_ack;
    reply_t reply;
    logic   rsp_req;
    logic   rsp_ack;

    udp_cmd_rx udp_cmd_rx_inst (
        .gmii_rx_clk  (gmii_rx_clk),
        .rst          (rst),
        .rec_en       (rec_en),
        .rec_data     (rec_data),
        .rec_pkt_done (rec_pkt_done),
        .cmd          (cmd),
        .cmd_req      (cmd_req),
        .cmd_ack      (cmd_ack)
    );

    axi_burst_master axi_burst_master_inst (
        .gmii_rx_clk (gmii_rx_clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_req     (cmd_req),
        .cmd_ack     (cmd_ack),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .b           (b),
        .bvalid      (bvalid),
        .bready      (bready),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .reply       (reply),
        .rsp_req     (rsp_req),
        .rsp_ack     (rsp_ack)
    );

    udp_reply_tx udp_reply_tx_inst (
        .gmii_rx_clk (gmii_rx_clk),
        .rst         (rst),
        .reply       (reply),
        .rsp_req     (rsp_req),
        .rsp_ack     (rsp_ack),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_req      (tx_req),
        .tx_data     (tx_data),
        .tx_done     (tx_done)
    );

endmodule

//--- rtl/udp_axi_pkg.sv
package udp_axi_pkg;

    localparam logic [3:0] max_beats = 4'd8;      // deepest burst handled
    localparam logic [7:0] tag_data  = 8'hFF;     // write-data packet
    localparam logic [7:0] tag_addr  = 8'h00;     // address packet
    localparam logic [7:0] reply_tag = 8'hA5;

    typedef enum logic [1:0] {
        op_write = 2'd0,
        op_read  = 2'd1
    } op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_aw,
        st_w,
        st_b,
        st_ar,
        st_r,
        st_reply
    } master_state_e;

    typedef struct packed {
        op_e                          op;
        logic [1:0]                   id;
        logic [1:0]                   burst;
        logic [2:0]                   len;     // beats minus one
        logic [31:0]                  addr;
        logic [max_beats-1:0][31:0]   wdata;
    } cmd_t;

    typedef struct packed {
        op_e                          op;
        logic [1:0]                   id;
        logic [1:0]                   resp;
        logic [2:0]                   len;
        logic [max_beats-1:0][31:0]   rdata;
    } reply_t;

    // shared by aw and ar
    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

//--- rtl/udp_cmd_rx.sv
`timescale 1ns/10ps
module udp_cmd_rx import udp_axi_pkg::*; (
    input  logic        gmii_rx_clk,
    input  logic        rst,
    input  logic        rec_en,
    input  logic [31:0] rec_data,
    input  logic        rec_pkt_done,
    output cmd_t        cmd,
    output logic        cmd_req,
    input  logic        cmd_ack
);
    logic [3:0]  word_cnt;
    logic [31:0] hdr_q;
    logic [31:0] addr_q;
    logic        skip;          // packet began while busy
    logic        pend_valid;
    logic [1:0]  pend_id;
    logic [1:0]  pend_burst;
    logic [2:0]  pend_len;
    logic [31:0] pend_addr;

    logic        busy;
    logic        take;
    logic        done_ok;
    logic [31:0] hdr_cur;
    logic [31:0] addr_cur;
    logic [3:0]  cnt_cur;
    logic [2:0]  widx;
    logic        is_addr;
    logic        got_rd;
    logic        got_wr_addr;
    logic        got_wr;

    assign busy     = cmd_req || cmd_ack;
    assign take     = rec_en && !busy && !skip;
    assign done_ok  = rec_pkt_done && !busy && !skip;

    // view of the packet including a word arriving this cycle
    assign hdr_cur  = (take && word_cnt == 4'd0) ? rec_data : hdr_q;
    assign addr_cur = (take && word_cnt == 4'd1) ? rec_data : addr_q;
    assign cnt_cur  = (take && word_cnt != 4'hF) ? word_cnt + 4'd1 : word_cnt;
    assign widx     = word_cnt[2:0] - 3'd1;  // data word 1 goes to slot 0

    assign is_addr     = (hdr_cur[31:24] == tag_addr) && (cnt_cur >= 4'd2);
    assign got_rd      = done_ok && is_addr && !hdr_cur[16];
    assign got_wr_addr = done_ok && is_addr && hdr_cur[16];
    assign got_wr      = done_ok && (hdr_cur[31:24] == tag_data) && pend_valid &&
                         (cnt_cur >= {1'b0, pend_len} + 4'd2);

    always_ff @(posedge gmii_rx_clk) begin
        if (rst) begin
            word_cnt   <= 4'd0;
            skip       <= 1'b0;
            pend_valid <= 1'b0;
            cmd_req    <= 1'b0;
        end else begin
            if (rec_pkt_done) begin
                word_cnt <= 4'd0;
            end else if (take && word_cnt != 4'hF) begin
                word_cnt <= word_cnt + 4'd1;
            end
            if (rec_pkt_done) begin
                skip <= 1'b0;
            end else if (rec_en && busy) begin
                skip <= 1'b1;
            end
            if (got_wr_addr) begin
                pend_valid <= 1'b1;
            end else if (got_wr) begin
                pend_valid <= 1'b0;
            end
            if (got_rd || got_wr) begin
                cmd_req <= 1'b1;
            end else if (cmd_ack) begin
                cmd_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (take && word_cnt == 4'd0) hdr_q <= rec_data;
        if (take && word_cnt == 4'd1) addr_q <= rec_data;
        if (take && hdr_q[31:24] == tag_data && word_cnt != 4'd0 && word_cnt <= max_beats) begin
            cmd.wdata[widx] <= rec_data;
        end
        if (got_wr_addr) begin
            pend_id    <= hdr_cur[21:20];
            pend_burst <= hdr_cur[23:22];
            pend_len   <= hdr_cur[10:8];
            pend_addr  <= addr_cur;
        end
        if (got_rd) begin
            cmd.op    <= op_read;
            cmd.id    <= hdr_cur[21:20];
            cmd.burst <= hdr_cur[23:22];
            cmd.len   <= hdr_cur[10:8];
            cmd.addr  <= addr_cur;
        end else if (got_wr) begin
            cmd.op    <= op_write;
            cmd.id    <= pend_id;
            cmd.burst <= pend_burst;
            cmd.len   <= pend_len;
            cmd.addr  <= pend_addr;
        end
    end

    // master may sample cmd on any cycle of the request
    assert property (@(posedge gmii_rx_clk) disable iff (rst)
        cmd_req |=> !cmd_req || $stable(cmd));

endmodule

//--- rtl/udp_reply_tx.sv
`timescale 1ns/10ps
module udp_reply_tx import udp_axi_pkg::*; (
    input  logic        gmii_rx_clk,
    input  logic        rst,
    input  reply_t      reply,
    input  logic        rsp_req,
    output logic        rsp_ack,
    output logic        tx_start_en,
    output logic [15:0] tx_byte_num,
    input  logic        tx_req,
    output logic [31:0] tx_data,
    input  logic        tx_done
);
    reply_t      rep_q;
    logic [3:0]  widx;          // next word to serve
    logic [3:0]  nwords;
    logic [2:0]  ridx;
    logic [31:0] status_word;
    logic        done_seen;
    logic        start;

    assign start = rsp_req && !rsp_ack;

    assign status_word = {reply_tag, 6'b0, rep_q.id, 6'b0, rep_q.resp, 5'b0, rep_q.len};
    assign nwords      = (rep_q.op == op_read) ? {1'b0, rep_q.len} + 4'd2 : 4'd1;
    assign tx_byte_num = {10'b0, nwords, 2'b00};
    assign ridx        = widx[2:0] - 3'd1;   // word 1 is rdata[0]

    always_ff @(posedge gmii_rx_clk) begin
        if (rst) begin
            rsp_ack     <= 1'b0;
            tx_start_en <= 1'b0;
            widx        <= 4'd0;
            done_seen   <= 1'b0;
        end else begin
            tx_start_en <= 1'b0;
            if (start) begin
                rsp_ack     <= 1'b1;
                tx_start_en <= 1'b1;     // same edge as rep_q, so byte count is valid
                widx        <= 4'd0;
                done_seen   <= 1'b0;
            end else if (rsp_ack) begin
                if (tx_req && widx != 4'hF) widx <= widx + 4'd1;
                if (tx_done) done_seen <= 1'b1;
                if (done_seen && !rsp_req) begin
                    rsp_ack   <= 1'b0;
                    done_seen <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (start) rep_q <= reply;
        if (rsp_ack && tx_req) begin
            if (widx == 4'd0) begin
                tx_data <= status_word;
            end else if (widx < nwords) begin
                tx_data <= rep_q.rdata[ridx];
            end else begin
                tx_data <= 32'd0;        // stack asked past the end
            end
        end
    end

    // stack asks only for words of the packet in flight
    assert property (@(posedge gmii_rx_clk) disable iff (rst)
        tx_req |-> rsp_ack && widx < nwords);

endmodule

//--- test/axi_slave_model.sv
`timescale 1ns/10ps
module axi_slave_model import udp_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  axi_aw_t     aw,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output axi_b_t      b,
    output logic        bvalid,
    input  logic        bready,
    input  axi_aw_t     ar,
    input  logic        arvalid,
    output logic        arready,
    output axi_r_t      r,
    output logic        rvalid,
    input  logic        rready
);
    logic [31:0] mem [0:255];
    logic [7:0]  wptr;
    logic [7:0]  rptr;
    logic [7:0]  rleft;         // beats still to send after this one
    logic [1:0]  wid;
    logic [1:0]  rid;
    logic        b_pend;
    logic        rd_busy;
    logic        awready_q;
    logic        wready_q;
    logic        arready_q;
    logic        bvalid_q;
    logic        rvalid_q;

    // quiet from time zero while rst is high
    assign awready = awready_q && !rst;
    assign wready  = wready_q && !rst;
    assign arready = arready_q && !rst;
    assign bvalid  = bvalid_q && !rst;
    assign rvalid  = rvalid_q && !rst;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            b_pend    <= 1'b0;
            rd_busy   <= 1'b0;
        end else begin
            awready_q <= ($urandom_range(0, 3) != 0);  // stall about one cycle in four
            wready_q  <= ($urandom_range(0, 3) != 0);
            arready_q <= ($urandom_range(0, 3) != 0);
            if (awvalid && awready) begin
                wptr <= aw.addr[9:2];               // every burst taken as INCR
                wid  <= aw.id;
            end
            if (wvalid && wready) begin
                for (int k = 0; k < 4; k++) begin
                    if (wstrb[k]) mem[wptr][8*k +: 8] <= wdata[8*k +: 8];  // enabled lanes
                end
                wptr <= wptr + 8'd1;
                if (wlast) b_pend <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid_q <= 1'b0;
            end else if (b_pend && !bvalid_q && $urandom_range(0, 2) == 0) begin
                bvalid_q <= 1'b1;
                b_pend   <= 1'b0;
                b.id     <= wid;
                b.resp   <= 2'b00;
            end
            if (arvalid && arready) begin
                rptr    <= ar.addr[9:2];
                rleft   <= ar.len;
                rid     <= ar.id;
                rd_busy <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid_q <= 1'b0;
                rptr     <= rptr + 8'd1;
                rleft    <= rleft - 8'd1;
                if (r.last) rd_busy <= 1'b0;
            end else if (rd_busy && !rvalid_q && $urandom_range(0, 2) != 0) begin
                rvalid_q <= 1'b1;
                r.id     <= rid;
                r.data   <= mem[rptr];
                r.resp   <= 2'b00;
                r.last   <= (rleft == 8'd0);
            end
        end
    end

endmodule

//--- test/tb_udp_axi_bridge.sv
`timescale 1ns/10ps
module tb_udp_axi_bridge import udp_axi_pkg::*; ();

    localparam int n_rows         = 10;
    localparam int timeout_cycles = 2000;
    localparam int quiet_cycles   = 300;    // no reply expected within this
    localparam logic [1:0] k_write  = 2'd0;
    localparam logic [1:0] k_read   = 2'd1;
    localparam logic [1:0] k_orphan = 2'd2; // data packet with no address before it

    typedef struct packed {
        logic [1:0]  kind;
        logic [1:0]  id;
        logic [2:0]  len;
        logic [31:0] addr;
        logic [31:0] data0;
        logic [31:0] status;   // expected reply word 0
        logic [15:0] nbytes;
    } test_row_t;

    logic        gmii_rx_clk = 1'b0;
    logic        rst;
    logic        rec_en;
    logic [31:0] rec_data;
    logic        rec_pkt_done;
    logic        tx_start_en;
    logic [15:0] tx_byte_num;
    logic        tx_req;
    logic [31:0] tx_data;
    logic        tx_done;
    axi_aw_t     aw;
    axi_aw_t     ar;
    axi_b_t      b;
    axi_r_t      r;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;

    test_row_t   rows [n_rows];
    string       row_name [n_rows];
    logic [31:0] exp_mem [0:255];
    logic [31:0] pkt_q [$];
    int          errors;
    test_row_t   cur_row;       // row in progress, for the address beat checks
    string       cur_name;
    int          bus_errs;

    always #5 gmii_rx_clk = ~gmii_rx_clk;

    udp_axi_bridge udp_axi_bridge_inst (.*);

    axi_slave_model axi_slave_model_inst (
        .clk (gmii_rx_clk), .rst (rst),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
        .b (b), .bvalid (bvalid), .bready (bready),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready)
    );

    task automatic load_table();
        rows[0] = '{k_write,  2'd1, 3'd3, 32'h40,  32'h1000_0000, 32'hA501_0003, 16'd4};
        row_name[0] = "wr4_a";
        rows[1] = '{k_read,   2'd1, 3'd3, 32'h40,  32'h0,         32'hA501_0003, 16'd20};
        row_name[1] = "rd4_a";
        rows[2] = '{k_write,  2'd2, 3'd0, 32'h100, 32'hCAFE_0001, 32'hA502_0000, 16'd4};
        row_name[2] = "wr1_b";
        rows[3] = '{k_read,   2'd2, 3'd0, 32'h100, 32'h0,         32'hA502_0000, 16'd8};
        row_name[3] = "rd1_b";
        rows[4] = '{k_orphan, 2'd0, 3'd1, 32'h0,   32'hDEAD_0000, 32'h0,         16'd0};
        row_name[4] = "orphan";
        rows[5] = '{k_write,  2'd3, 3'd7, 32'h200, 32'h5A00_0000, 32'hA503_0007, 16'd4};
        row_name[5] = "wr8_c";
        rows[6] = '{k_read,   2'd0, 3'd7, 32'h200, 32'h0,         32'hA500_0007, 16'd36};
        row_name[6] = "rd8_c";
        rows[7] = '{k_write,  2'd0, 3'd1, 32'h50,  32'h7700_0000, 32'hA500_0001, 16'd4};
        row_name[7] = "wr2_d";
        rows[8] = '{k_read,   2'd3, 3'd3, 32'h40,  32'h0,         32'hA503_0003, 16'd20};
        row_name[8] = "rd4_a2";
        rows[9] = '{k_read,   2'd1, 3'd1, 32'h50,  32'h0,         32'hA501_0001, 16'd12};
        row_name[9] = "rd2_d";
    endtask

    task automatic send_packet();
        foreach (pkt_q[i]) begin
            @(posedge gmii_rx_clk);
            rec_en   <= 1'b1;
            rec_data <= pkt_q[i];
        end
        @(posedge gmii_rx_clk);
        rec_en       <= 1'b0;
        rec_pkt_done <= 1'b1;
        @(posedge gmii_rx_clk);
        rec_pkt_done <= 1'b0;
        pkt_q.delete();
    endtask

    task automatic send_addr(input test_row_t row, input logic wr);
        // byte 2 is {burst, id, 3'b0, wr}, burst INCR
        pkt_q.push_back({tag_addr, 2'b01, row.id, 3'b000, wr, 5'b00000, row.len, 8'h00});
        pkt_q.push_back(row.addr);
        send_packet();
        repeat (2) @(posedge gmii_rx_clk);
    endtask

    task automatic send_data(input test_row_t row);
        pkt_q.push_back({tag_data, 24'h0});
        for (int i = 0; i <= int'(row.len); i++) begin
            pkt_q.push_back(row.data0 + 32'(i));
        end
        send_packet();
    endtask

    // AXI address beat must carry the id, address and len of the command, burst INCR
    task automatic check_addr_beat(input string chan, input axi_aw_t got);
        axi_aw_t exp_beat;
        exp_beat.id    = cur_row.id;
        exp_beat.addr  = cur_row.addr;
        exp_beat.len   = 8'(cur_row.len);
        exp_beat.burst = 2'b01;
        if (got !== exp_beat) begin
            $display("MISMATCH %s %s expected %h actual %h", cur_name, chan, exp_beat, got);
            bus_errs++;
        end
    endtask

    always @(negedge gmii_rx_clk) begin
        if (!rst && awvalid && awready) check_addr_beat("aw", aw);
        if (!rst && arvalid && arready) check_addr_beat("ar", ar);
    end

    // UDP stack side: take the transmit, pull each word, then signal done
    task automatic take_reply(input string name, input test_row_t row, output int errs);
        int          wait_cnt;
        int          nwords;
        logic [7:0]  idx;
        logic [31:0] exp_word;
        logic [31:0] got;
        errs = 0;
        wait_cnt = 0;
        @(negedge gmii_rx_clk);
        while (!tx_start_en && wait_cnt < timeout_cycles) begin
            @(negedge gmii_rx_clk);
            wait_cnt++;
        end
        if (!tx_start_en) begin
            $display("%s: no reply started within %0d cycles", name, timeout_cycles);
            errs = 1;
            return;
        end
        if (tx_byte_num !== row.nbytes) begin
            $display("MISMATCH %s tx_byte_num expected %0d actual %0d",
                     name, row.nbytes, tx_byte_num);
            errs++;
        end
        nwords = int'(row.nbytes) / 4;
        for (int i = 0; i < nwords; i++) begin
            repeat ($urandom_range(0, 3)) @(posedge gmii_rx_clk);
            @(posedge gmii_rx_clk);
            tx_req <= 1'b1;
            @(posedge gmii_rx_clk);
            tx_req <= 1'b0;
            @(negedge gmii_rx_clk);
            got = tx_data;
            idx = row.addr[9:2] + 8'(i - 1);
            exp_word = (i == 0) ? row.status : exp_mem[idx];
            if (got !== exp_word) begin
                $display("MISMATCH %s word %0d expected %h actual %h", name, i, exp_word, got);
                errs++;
            end
        end
        @(posedge gmii_rx_clk);
        tx_done <= 1'b1;
        @(posedge gmii_rx_clk);
        tx_done <= 1'b0;
        repeat (3) @(posedge gmii_rx_clk);
    endtask

    task automatic expect_silence(input string name, output int errs);
        int cnt;
        errs = 0;
        cnt = 0;
        while (!tx_start_en && cnt < quiet_cycles) begin
            @(negedge gmii_rx_clk);
            cnt++;
        end
        if (tx_start_en) begin
            $display("%s: a reply was sent for a data packet with no write address", name);
            errs = 1;
        end
    endtask

    task automatic run_row(input int n, output int errs);
        test_row_t row;
        row = rows[n];
        cur_row = row;
        cur_name = row_name[n];
        case (row.kind)
            k_write: begin
                send_addr(row, 1'b1);
                send_data(row);
                for (int i = 0; i <= int'(row.len); i++) begin
                    exp_mem[row.addr[9:2] + 8'(i)] = row.data0 + 32'(i);
                end
                take_reply(row_name[n], row, errs);
            end
            k_read: begin
                send_addr(row, 1'b0);
                take_reply(row_name[n], row, errs);
            end
            default: begin
                send_data(row);
                expect_silence(row_name[n], errs);
            end
        endcase
    endtask

    initial begin
        int errs;
        int failed;
        void'($urandom(32'haa991f32));
        rst          = 1'b1;
        rec_en       = 1'b0;
        rec_data     = 32'd0;
        rec_pkt_done = 1'b0;
        tx_req       = 1'b0;
        tx_done      = 1'b0;
        errors       = 0;
        bus_errs     = 0;
        failed       = 0;
        load_table();
        repeat (8) @(posedge gmii_rx_clk);
        rst <= 1'b0;
        repeat (2) @(posedge gmii_rx_clk);
        for (int n = 0; n < n_rows; n++) begin
            run_row(n, errs);
            errs += bus_errs;
            bus_errs = 0;
            if (errs == 0) begin
                $display("test %s: ok", row_name[n]);
            end else begin
                $display("test %s: %0d errors", row_name[n], errs);
                failed++;
            end
            errors += errs;
        end
        $display("%0d tests run, %0d failed, %0d errors in total", n_rows, failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/udp_axi_pkg.sv
rtl/udp_cmd_rx.sv
rtl/axi_burst_master.sv
rtl/udp_reply_tx.sv
rtl/udp_axi_bridge.sv
test/axi_slave_model.sv
test/tb_udp_axi_bridge.sv
